/* dv/tb_frames.svh */
`ifndef TB_FRAMES_SVH
`define TB_FRAMES_SVH

////////////////////////////////////////////////////////////
// random source, xorshift32
function automatic logic [31:0] next_random();
	rng = rng ^ (rng << 13);
	rng = rng ^ (rng >> 17);
	rng = rng ^ (rng << 5);
	return rng;
endfunction

// new frame header with a random serial and random upper command bits
task automatic start_frame(input logic [cmd_pkg::OPCODE_W-1:0] op);
	serial = next_random();
	cmd    = next_random();
	cmd[cmd_pkg::OPCODE_W-1:0] = op; // opcode lives in the low bits
	frame.delete();
	frame.push_back(serial);
	frame.push_back(cmd);
endtask

////////////////////////////////////////////////////////////
// send frame and collect the response, one cycle per pass
task automatic transact();
	int sent;
	int cycles;
	bit got_last;
	sent     = 0;
	cycles   = 0;
	got_last = 1'b0;
	resp_data.delete();
	resp_last.delete();
	while (!got_last && cycles < FRAME_TIMEOUT) begin
		@(negedge clk);
		rx_tvalid = (sent < frame.size());
		rx_data   = rx_tvalid ? frame[sent] : '0;
		rx_tlast  = (sent == frame.size() - 1);
		tx_tready = (next_random() % 4) != 0; // random back-pressure
		#SETTLE; // outputs now stable until the rising edge
		if (rx_tvalid && rx_tready) sent++;
		if (tx_tvalid && tx_tready) begin
			resp_data.push_back(tx_data);
			resp_last.push_back(tx_tlast);
			got_last = tx_tlast;
		end
		cycles++;
	end
	@(negedge clk);
	rx_tvalid = 1'b0;
	rx_tlast  = 1'b0;
	if (!got_last) begin
		errors++;
		$display("timeout: the response to the frame never ended");
	end else if (sent != frame.size()) begin
		errors++;
		$display("the DUT did not accept every word of the frame");
	end
endtask

// wait for the dispatcher to come back to idle
task automatic wait_idle();
	int cycles;
	cycles = 0;
	do begin
		@(negedge clk);
		tx_tready = (next_random() % 4) != 0;
		cycles++;
	end while (!cmd_idle && cycles < IDLE_TIMEOUT);
	if (!cmd_idle) begin
		errors++;
		$display("timeout: the command processor never returned to idle");
	end
endtask

`endif

/* dv/tb_command_top.sv */
module tb_command_top;

	localparam logic [cmd_pkg::BURST_W-1:0] DEFAULT_BURSTS = 23'd1500;
	localparam int FRAME_TIMEOUT = 400; // cycles per frame
	localparam int IDLE_TIMEOUT  = 50;
	localparam int SETTLE        = 1;   // combinational settle after a drive

	logic clk = 1'b0;
	logic reset;
	logic [31:0] rx_data, tx_data;
	logic rx_tvalid, rx_tlast, rx_tready, tx_tvalid, tx_tlast, tx_tready;
	logic [cmd_pkg::FILL_W-1:0] fill_num;
	logic [cmd_pkg::CH_ADDR_W-1:0] ch_addr;
	logic [cmd_pkg::TAG_W-1:0] channel_tag;
	logic [cmd_pkg::BURST_W-1:0] muon_num_bursts, laser_num_bursts, ped_num_bursts;
	logic cmd_idle;

	logic [31:0] rng = 32'h5fe7_2e7e;
	logic [31:0] serial, cmd, rnd, trunc;
	logic [31:0] frame[$], expect_q[$], resp_data[$];
	logic resp_last[$];
	logic [31:0] cfg_model[4];                // written values, truncated
	int errors = 0, test_start, tests_run = 0, tests_failed = 0;
	string port_name[4] = '{"channel_tag", "muon_num_bursts", "laser_num_bursts",
		"ped_num_bursts"};

	always #50 clk = ~clk;

	command_top #(.DEFAULT_BURSTS(DEFAULT_BURSTS)) uut (.*);

	`include "tb_frames.svh"

	// a stalled response word must not change
	tx_hold: assert property (@(posedge clk) disable iff (reset)
		tx_tvalid && !tx_tready |=> tx_tvalid && $stable(tx_data) && $stable(tx_tlast))
		else begin
			errors++;
			$display("FAILED tx stream changed while stalled: tx_data now %h, tx_tlast %h",
				tx_data, tx_tlast);
		end

	task automatic check_value(input string name, input logic [95:0] exp,
		input logic [95:0] act);
		assert (act === exp) else begin
			errors++;
			$display("FAILED %s: expected %0h, got %0h", name, exp, act);
		end
	endtask

	task automatic expect_reply(input bit ok);
		expect_q.delete();
		expect_q.push_back(serial);
		expect_q.push_back(ok ? cmd : ~cmd); // inverted command flags a failure
	endtask

	task automatic check_response();
		int i;
		check_value("response length", expect_q.size(), resp_data.size());
		for (i = 0; i < resp_data.size() && i < expect_q.size(); i++) begin
			check_value("tx_data", expect_q[i], resp_data[i]);
			check_value("tx_tlast", i == expect_q.size() - 1, resp_last[i]);
		end
	endtask

	task automatic read_reg(input logic [31:0] num, input logic [31:0] exp,
		input bit ok);
		start_frame(cmd_pkg::CC_RD_REG);
		frame.push_back(num);
		expect_reply(ok);
		if (ok) expect_q.push_back(exp); // illegal read has no data word
		transact();
		check_response();
		wait_idle();
	endtask

	task automatic write_reg(input logic [31:0] num, input logic [31:0] val,
		input bit ok);
		start_frame(cmd_pkg::CC_WR_REG);
		frame.push_back(num);
		frame.push_back(val);
		expect_reply(ok);
		transact();
		check_response();
		wait_idle();
	endtask

	function automatic logic [31:0] config_port(input int num);
		case (num)
			0:       return 32'(channel_tag);
			1:       return 32'(muon_num_bursts);
			2:       return 32'(laser_num_bursts);
			default: return 32'(ped_num_bursts);
		endcase
	endfunction

	task automatic finish_test(input string name);
		tests_run++;
		if (errors == test_start) $display("test %s: ok", name);
		else begin
			tests_failed++;
			$display("test %s: %0d errors", name, errors - test_start);
		end
	endtask

	////////////////////////////////////////////////////////////
	// test sequence
	initial begin
		reset     = 1'b1;
		rx_data   = '0;
		rx_tvalid = 1'b0;
		rx_tlast  = 1'b0;
		tx_tready = 1'b0;
		fill_num  = '0;
		ch_addr   = '0;
		repeat (4) @(posedge clk);
		@(negedge clk) reset = 1'b0;

		test_start = errors;
		check_value("tx_tvalid", 0, tx_tvalid);
		check_value("cmd_idle", 1, cmd_idle);
		check_value("rx_tready", 1, rx_tready);
		check_value("channel_tag", cmd_pkg::TAG_RESET, channel_tag);
		for (int r = 1; r < 4; r++) check_value(port_name[r], DEFAULT_BURSTS, config_port(r));
		finish_test("reset");

		test_start = errors;
		repeat (4) begin // loopback, 1 to 8 payload words
			start_frame(cmd_pkg::CC_LOOPBACK);
			expect_reply(1'b1);
			repeat (1 + next_random() % 8) begin
				rnd = next_random();
				frame.push_back(rnd);
				expect_q.push_back(rnd);
			end
			transact();
			check_response();
			wait_idle();
		end
		finish_test("loopback");

		test_start = errors;
		for (int r = 0; r < 4; r++) begin
			rnd   = next_random();
			trunc = rnd & ((32'd1 << (r == 0 ? cmd_pkg::TAG_W : cmd_pkg::BURST_W)) - 1);
			cfg_model[r] = trunc;
			write_reg(r, rnd, 1'b1);
			check_value(port_name[r], trunc, config_port(r));
			read_reg(r, trunc, 1'b1); // zero extended read back
		end
		finish_test("register write");

		test_start = errors;
		rnd      = next_random();
		fill_num = rnd[cmd_pkg::FILL_W-1:0];
		ch_addr  = 3'b110; // jumpers read back corrected
		read_reg(cmd_pkg::REG_FILL_NUM, rnd & 32'h00ff_ffff, 1'b1);
		read_reg(cmd_pkg::REG_CH_ADDR, 32'd3, 1'b1);
		ch_addr = 3'b010;
		read_reg(cmd_pkg::REG_CH_ADDR, 32'd2, 1'b1);
		finish_test("read-only registers");

		test_start = errors;
		read_reg(32'd9, 32'd0, 1'b0);
		write_reg(cmd_pkg::REG_FILL_NUM, next_random(), 1'b0);
		start_frame(5'd7); // unknown opcode, payload drained
		repeat (3) frame.push_back(next_random());
		expect_reply(1'b0);
		transact();
		check_response();
		wait_idle();
		for (int r = 0; r < 4; r++) check_value(port_name[r], cfg_model[r], config_port(r));
		finish_test("error responses");

		$display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed,
			errors);
		if (errors == 0) $display("TESTS PASSED");
		else $display("TESTS FAILED");
		$finish;
	end

endmodule

/* rtl/cmd_pkg.sv */
package cmd_pkg;

	//////////////////////////////////////////////////////////////
	// field widths
	localparam int WORD_W    = 32; // stream word
	localparam int OPCODE_W  = 5;  // low bits of the command word
	localparam int REG_NUM_W = 8;  // register number kept from the payload
	localparam int BURST_W   = 23; // burst count registers
	localparam int TAG_W     = 16; // channel tag
	localparam int FILL_W    = 24; // fill number
	localparam int CH_ADDR_W = 3;  // channel address jumpers

	//////////////////////////////////////////////////////////////
	// command codes, anything else is answered as unknown
	typedef enum logic [OPCODE_W-1:0] {
		CC_LOOPBACK = 5'd1,
		CC_RD_REG   = 5'd2,
		CC_WR_REG   = 5'd3
	} cmd_opcode_e;

	// source of the next word in the transmit data register
	typedef enum logic [2:0] {
		TX_SEL_CSN,     // serial number echo
		TX_SEL_CMD,     // command word, success
		TX_SEL_INV_CMD, // inverted command, failure
		TX_SEL_RX,      // receive data, loopback
		TX_SEL_REG      // register bank read data
	} tx_sel_e;

	//////////////////////////////////////////////////////////////
	// register map
	localparam logic [REG_NUM_W-1:0] REG_CHANNEL_TAG  = 8'd0; // r/w
	localparam logic [REG_NUM_W-1:0] REG_MUON_BURSTS  = 8'd1; // r/w
	localparam logic [REG_NUM_W-1:0] REG_LASER_BURSTS = 8'd2; // r/w
	localparam logic [REG_NUM_W-1:0] REG_PED_BURSTS   = 8'd3; // r/w
	localparam logic [REG_NUM_W-1:0] REG_FILL_NUM     = 8'd4; // read only
	localparam logic [REG_NUM_W-1:0] REG_CH_ADDR      = 8'd5; // read only

	localparam logic [TAG_W-1:0] TAG_RESET = 16'h0000;

endpackage

/* rtl/command_dispatch.sv */
module command_dispatch (
	input  logic                       clk,
	input  logic                       reset,
	input  logic [cmd_pkg::WORD_W-1:0] rx_data,
	input  logic                       rx_tvalid,
	input  logic                       rx_tlast,
	output logic                       rx_tready,
	output logic [cmd_pkg::WORD_W-1:0] tx_data,
	output logic                       tx_tvalid,
	output logic                       tx_tlast,
	input  logic                       tx_tready,
	input  logic                       lb_rx_tready,
	input  logic                       lb_tx_tvalid,
	input  logic                       lb_tx_tlast,
	input  logic                       lb_tx_load,
	input  cmd_pkg::tx_sel_e           lb_tx_sel,
	input  logic                       ra_rx_tready,
	input  logic                       ra_tx_tvalid,
	input  logic                       ra_tx_tlast,
	input  logic                       ra_tx_load,
	input  cmd_pkg::tx_sel_e           ra_tx_sel,
	input  logic                       lb_done,
	input  logic                       ra_done,
	input  logic [cmd_pkg::WORD_W-1:0] reg_rdata,
	output logic                       run_loopback,
	output logic                       run_rd_reg,
	output logic                       run_wr_reg,
	output logic                       cmd_idle
);
	typedef enum logic [2:0] {
		S_GET_CSN, S_GET_CMD, S_DECODE, S_RUN, S_DRAIN, S_ERR_CSN, S_ERR_CMD
	} state_e;

	state_e                      state, state_nxt;
	logic [cmd_pkg::WORD_W-1:0]  serial_reg, cmd_reg; // frame header
	logic                        cmd_last;            // frame ended on the command word
	cmd_pkg::cmd_opcode_e        opcode;
	logic                        own_rx_tready, own_tx_tvalid, own_tx_tlast, own_load;
	cmd_pkg::tx_sel_e            own_sel, tx_sel;
	logic                        tx_load;
	logic                        known_op;

	assign opcode   = cmd_pkg::cmd_opcode_e'(cmd_reg[cmd_pkg::OPCODE_W-1:0]);
	assign known_op = (opcode == cmd_pkg::CC_LOOPBACK) || (opcode == cmd_pkg::CC_RD_REG)
		|| (opcode == cmd_pkg::CC_WR_REG);
	assign run_loopback = (state == S_DECODE) && (opcode == cmd_pkg::CC_LOOPBACK);
	assign run_rd_reg   = (state == S_DECODE) && (opcode == cmd_pkg::CC_RD_REG);
	assign run_wr_reg   = (state == S_DECODE) && (opcode == cmd_pkg::CC_WR_REG);
	assign cmd_idle     = (state == S_GET_CSN); // waiting for a new frame

	// only one engine runs at a time, so plain OR merges the stream controls
	assign rx_tready = own_rx_tready | lb_rx_tready | ra_rx_tready;
	assign tx_tvalid = own_tx_tvalid | lb_tx_tvalid | ra_tx_tvalid;
	assign tx_tlast  = own_tx_tlast | lb_tx_tlast | ra_tx_tlast;
	assign tx_load   = own_load | lb_tx_load | ra_tx_load;
	assign tx_sel    = lb_tx_load ? lb_tx_sel : (ra_tx_load ? ra_tx_sel : own_sel);

	always_ff @(posedge clk) begin
		if (reset) state <= S_GET_CSN;
		else       state <= state_nxt;
	end

	//////////////////////////////////////////////////////////////
	// header registers and transmit data register
	always_ff @(posedge clk) begin
		if (state == S_GET_CSN && rx_tvalid) serial_reg <= rx_data;
		if (state == S_GET_CMD && rx_tvalid) begin
			cmd_reg  <= rx_data;
			cmd_last <= rx_tlast; // nothing to drain if set
		end
		if (tx_load) begin
			case (tx_sel)
				cmd_pkg::TX_SEL_CSN:     tx_data <= serial_reg;
				cmd_pkg::TX_SEL_CMD:     tx_data <= cmd_reg;
				cmd_pkg::TX_SEL_INV_CMD: tx_data <= ~cmd_reg;
				cmd_pkg::TX_SEL_RX:      tx_data <= rx_data;   // loopback
				default:                 tx_data <= reg_rdata; // register read
			endcase
		end
	end

	always_comb begin
		state_nxt     = state;
		own_rx_tready = 1'b0;
		own_tx_tvalid = 1'b0;
		own_tx_tlast  = 1'b0;
		own_load      = 1'b0;
		own_sel       = cmd_pkg::TX_SEL_CSN;
		case (state)
			S_GET_CSN: begin
				own_rx_tready = 1'b1;
				if (rx_tvalid) state_nxt = S_GET_CMD;
			end
			S_GET_CMD: begin
				own_rx_tready = 1'b1;
				if (rx_tvalid) state_nxt = S_DECODE;
			end
			S_DECODE: begin // run pulse goes out here
				if (known_op) state_nxt = S_RUN;
				else if (cmd_last) begin
					own_load  = 1'b1; // straight to the error reply
					state_nxt = S_ERR_CSN;
				end else state_nxt = S_DRAIN;
			end
			S_RUN: if (lb_done || ra_done) state_nxt = S_GET_CSN;
			S_DRAIN: begin // discard rest of unknown frame
				own_rx_tready = 1'b1;
				if (rx_tvalid && rx_tlast) begin
					own_load  = 1'b1;
					state_nxt = S_ERR_CSN;
				end
			end
			S_ERR_CSN: begin
				own_tx_tvalid = 1'b1;
				if (tx_tready) begin
					own_load  = 1'b1;
					own_sel   = cmd_pkg::TX_SEL_INV_CMD;
					state_nxt = S_ERR_CMD;
				end
			end
			S_ERR_CMD: begin
				own_tx_tvalid = 1'b1;
				own_tx_tlast  = 1'b1;
				if (tx_tready) state_nxt = S_GET_CSN;
			end
			default: state_nxt = S_GET_CSN;
		endcase
	end

endmodule

/* rtl/command_top.sv */
module command_top #(
	parameter logic [cmd_pkg::BURST_W-1:0] DEFAULT_BURSTS = 23'd1024
) (
	input  logic                          clk,
	input  logic                          reset,
	input  logic [cmd_pkg::WORD_W-1:0]    rx_data,
	input  logic                          rx_tvalid,
	input  logic                          rx_tlast,
	output logic                          rx_tready,
	output logic [cmd_pkg::WORD_W-1:0]    tx_data,
	output logic                          tx_tvalid,
	output logic                          tx_tlast,
	input  logic                          tx_tready,
	input  logic [cmd_pkg::FILL_W-1:0]    fill_num,
	input  logic [cmd_pkg::CH_ADDR_W-1:0] ch_addr,
	output logic [cmd_pkg::TAG_W-1:0]     channel_tag,
	output logic [cmd_pkg::BURST_W-1:0]   muon_num_bursts,
	output logic [cmd_pkg::BURST_W-1:0]   laser_num_bursts,
	output logic [cmd_pkg::BURST_W-1:0]   ped_num_bursts,
	output logic                          cmd_idle
);
	// engine stream controls
	logic lb_rx_tready, lb_tx_tvalid, lb_tx_tlast, lb_tx_load, lb_done;
	logic ra_rx_tready, ra_tx_tvalid, ra_tx_tlast, ra_tx_load, ra_done;
	cmd_pkg::tx_sel_e lb_tx_sel, ra_tx_sel;
	logic run_loopback, run_rd_reg, run_wr_reg; // start pulses
	// register bank side
	logic reg_num_le, wr_en, rd_en, illegal_reg_num;
	logic [cmd_pkg::WORD_W-1:0] reg_rdata;

	//////////////////////////////////////////////////////////////
	// frame header handling and transmit data
	command_dispatch dispatch (.clk, .reset, .rx_data, .rx_tvalid, .rx_tlast, .rx_tready,
		.tx_data, .tx_tvalid, .tx_tlast, .tx_tready,
		.lb_rx_tready, .lb_tx_tvalid, .lb_tx_tlast, .lb_tx_load, .lb_tx_sel,
		.ra_rx_tready, .ra_tx_tvalid, .ra_tx_tlast, .ra_tx_load, .ra_tx_sel,
		.lb_done, .ra_done, .reg_rdata, .run_loopback, .run_rd_reg, .run_wr_reg, .cmd_idle);

	//////////////////////////////////////////////////////////////
	// command engines
	loopback_engine loopback (.clk, .reset, .run(run_loopback), .rx_tvalid, .rx_tlast,
		.rx_tready(lb_rx_tready), .tx_tvalid(lb_tx_tvalid), .tx_tlast(lb_tx_tlast),
		.tx_tready, .tx_load(lb_tx_load), .tx_sel(lb_tx_sel), .done(lb_done));

	reg_access_engine reg_access (.clk, .reset, .run_rd(run_rd_reg), .run_wr(run_wr_reg),
		.rx_tvalid, .rx_tready(ra_rx_tready), .tx_tvalid(ra_tx_tvalid),
		.tx_tlast(ra_tx_tlast), .tx_tready, .tx_load(ra_tx_load), .tx_sel(ra_tx_sel),
		.reg_num_le, .wr_en, .rd_en, .illegal_reg_num, .done(ra_done));

	//////////////////////////////////////////////////////////////
	// configuration registers
	config_regs #(
		.DEFAULT_BURSTS(DEFAULT_BURSTS)
	) regs (
		.clk, .reset, .rx_data, .reg_num_le, .wr_en, .rd_en, .fill_num, .ch_addr,
		.reg_rdata, .illegal_reg_num, .channel_tag, .muon_num_bursts,
		.laser_num_bursts, .ped_num_bursts
	);

endmodule

/* rtl/config_regs.sv */
module config_regs #(
	parameter logic [cmd_pkg::BURST_W-1:0] DEFAULT_BURSTS = 23'd1024
) (
	input  logic                         clk,
	input  logic                         reset,
	input  logic [cmd_pkg::WORD_W-1:0]   rx_data,
	input  logic                         reg_num_le,
	input  logic                         wr_en,
	input  logic                         rd_en,
	input  logic [cmd_pkg::FILL_W-1:0]   fill_num,
	input  logic [cmd_pkg::CH_ADDR_W-1:0] ch_addr,
	output logic [cmd_pkg::WORD_W-1:0]   reg_rdata,
	output logic                         illegal_reg_num,
	output logic [cmd_pkg::TAG_W-1:0]    channel_tag,
	output logic [cmd_pkg::BURST_W-1:0]  muon_num_bursts,
	output logic [cmd_pkg::BURST_W-1:0]  laser_num_bursts,
	output logic [cmd_pkg::BURST_W-1:0]  ped_num_bursts
);
	logic [cmd_pkg::REG_NUM_W-1:0] reg_num; // captured register number
	logic                          wr_flag; // transaction is a write
	logic [cmd_pkg::CH_ADDR_W-1:0] ch_addr_q;
	logic [cmd_pkg::WORD_W-1:0]    rd_mux;

	// read-only registers can not be written, past 5 nothing exists
	assign illegal_reg_num = (reg_num > cmd_pkg::REG_CH_ADDR) || (wr_flag
		&& (reg_num == cmd_pkg::REG_FILL_NUM || reg_num == cmd_pkg::REG_CH_ADDR));

	// jumpers on channel 3 are fitted as 110
	always_ff @(posedge clk) ch_addr_q <= (ch_addr == 3'b110) ? 3'b011 : ch_addr;

	//////////////////////////////////////////////////////////////
	// number capture and register writes
	always_ff @(posedge clk) begin
		if (reset) begin
			reg_num          <= '0;
			wr_flag          <= 1'b0;
			channel_tag      <= cmd_pkg::TAG_RESET;
			muon_num_bursts  <= DEFAULT_BURSTS;
			laser_num_bursts <= DEFAULT_BURSTS;
			ped_num_bursts   <= DEFAULT_BURSTS;
		end else if (reg_num_le) begin
			reg_num <= rx_data[cmd_pkg::REG_NUM_W-1:0];
			wr_flag <= wr_en; // wr_en here only marks the transaction
		end else if (wr_en && !illegal_reg_num) begin
			case (reg_num) // keep the low bits only
				cmd_pkg::REG_CHANNEL_TAG:  channel_tag      <= rx_data[cmd_pkg::TAG_W-1:0];
				cmd_pkg::REG_MUON_BURSTS:  muon_num_bursts  <= rx_data[cmd_pkg::BURST_W-1:0];
				cmd_pkg::REG_LASER_BURSTS: laser_num_bursts <= rx_data[cmd_pkg::BURST_W-1:0];
				cmd_pkg::REG_PED_BURSTS:   ped_num_bursts   <= rx_data[cmd_pkg::BURST_W-1:0];
				default: ;
			endcase
		end
	end

	// read mux, zero extended to a full word
	always_comb begin
		rd_mux = '0;
		case (reg_num)
			cmd_pkg::REG_CHANNEL_TAG:  rd_mux[cmd_pkg::TAG_W-1:0]     = channel_tag;
			cmd_pkg::REG_MUON_BURSTS:  rd_mux[cmd_pkg::BURST_W-1:0]   = muon_num_bursts;
			cmd_pkg::REG_LASER_BURSTS: rd_mux[cmd_pkg::BURST_W-1:0]   = laser_num_bursts;
			cmd_pkg::REG_PED_BURSTS:   rd_mux[cmd_pkg::BURST_W-1:0]   = ped_num_bursts;
			cmd_pkg::REG_FILL_NUM:     rd_mux[cmd_pkg::FILL_W-1:0]    = fill_num;
			cmd_pkg::REG_CH_ADDR:      rd_mux[cmd_pkg::CH_ADDR_W-1:0] = ch_addr_q;
			default:                   rd_mux = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rd_en) reg_rdata <= rd_mux; // held until the engine sends it
	end

endmodule

/* rtl/loopback_engine.sv */
module loopback_engine (
	input  logic             clk,
	input  logic             reset,
	input  logic             run,
	input  logic             rx_tvalid,
	input  logic             rx_tlast,
	output logic             rx_tready,
	output logic             tx_tvalid,
	output logic             tx_tlast,
	input  logic             tx_tready,
	output logic             tx_load,
	output cmd_pkg::tx_sel_e tx_sel,
	output logic             done
);
	typedef enum logic [2:0] {
		S_IDLE, S_SEND_CSN, S_SEND_CMD, S_GET_WORD, S_SEND_WORD
	} state_e;

	state_e state, state_nxt;
	logic   last_q; // echoed word closes the frame

	always_ff @(posedge clk) begin
		if (reset) begin
			state  <= S_IDLE;
			last_q <= 1'b0;
			done   <= 1'b0;
		end else begin
			state <= state_nxt;
			if (state == S_GET_WORD && rx_tvalid) last_q <= rx_tlast;
			done <= (state == S_SEND_WORD) && tx_tready && last_q;
		end
	end

	always_comb begin
		state_nxt = state;
		rx_tready = 1'b0;
		tx_tvalid = 1'b0;
		tx_tlast  = 1'b0;
		tx_load   = 1'b0;
		tx_sel    = cmd_pkg::TX_SEL_CSN;
		case (state)
			S_IDLE: if (run) begin
				tx_load   = 1'b1; // serial number first
				state_nxt = S_SEND_CSN;
			end
			S_SEND_CSN: begin
				tx_tvalid = 1'b1;
				if (tx_tready) begin
					tx_load   = 1'b1;
					tx_sel    = cmd_pkg::TX_SEL_CMD;
					state_nxt = S_SEND_CMD;
				end
			end
			S_SEND_CMD: begin
				tx_tvalid = 1'b1;
				if (tx_tready) state_nxt = S_GET_WORD;
			end
			S_GET_WORD: begin // take one word only once the previous echo left
				rx_tready = 1'b1;
				if (rx_tvalid) begin
					tx_load   = 1'b1;
					tx_sel    = cmd_pkg::TX_SEL_RX;
					state_nxt = S_SEND_WORD;
				end
			end
			S_SEND_WORD: begin
				tx_tvalid = 1'b1;
				tx_tlast  = last_q;
				if (tx_tready) state_nxt = last_q ? S_IDLE : S_GET_WORD;
			end
			default: state_nxt = S_IDLE;
		endcase
	end

endmodule

/* rtl/reg_access_engine.sv */
module reg_access_engine (
	input  logic             clk,
	input  logic             reset,
	input  logic             run_rd,
	input  logic             run_wr,
	input  logic             rx_tvalid,
	output logic             rx_tready,
	output logic             tx_tvalid,
	output logic             tx_tlast,
	input  logic             tx_tready,
	output logic             tx_load,
	output cmd_pkg::tx_sel_e tx_sel,
	output logic             reg_num_le,
	output logic             wr_en,
	output logic             rd_en,
	input  logic             illegal_reg_num,
	output logic             done
);
	typedef enum logic [2:0] {
		S_IDLE, S_GET_NUM, S_GET_DATA, S_LOAD_CSN, S_SEND_CSN, S_SEND_CMD, S_SEND_REG
	} state_e;

	state_e state, state_nxt;
	logic   is_wr;    // write transaction
	logic   last_cmd; // reply ends on the second word

	assign last_cmd = is_wr | illegal_reg_num;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= S_IDLE;
			is_wr <= 1'b0;
			done  <= 1'b0;
		end else begin
			state <= state_nxt;
			if (run_rd || run_wr) is_wr <= run_wr;
			done <= tx_tready && ((state == S_SEND_CMD && last_cmd) || state == S_SEND_REG);
		end
	end

	always_comb begin
		state_nxt  = state;
		rx_tready  = 1'b0;
		tx_tvalid  = 1'b0;
		tx_tlast   = 1'b0;
		tx_load    = 1'b0;
		tx_sel     = cmd_pkg::TX_SEL_CSN;
		reg_num_le = 1'b0;
		wr_en      = 1'b0;
		rd_en      = 1'b0;
		case (state)
			S_IDLE: if (run_rd || run_wr) state_nxt = S_GET_NUM;
			S_GET_NUM: begin
				rx_tready  = 1'b1;
				reg_num_le = rx_tvalid;
				wr_en      = rx_tvalid & is_wr; // tells the bank this is a write
				if (rx_tvalid) state_nxt = is_wr ? S_GET_DATA : S_LOAD_CSN;
			end
			S_GET_DATA: begin // data word always taken, stored only if legal
				rx_tready = 1'b1;
				wr_en     = rx_tvalid & ~illegal_reg_num;
				if (rx_tvalid) state_nxt = S_LOAD_CSN;
			end
			S_LOAD_CSN: begin
				tx_load   = 1'b1;
				rd_en     = ~is_wr; // read data ready long before it is sent
				state_nxt = S_SEND_CSN;
			end
			S_SEND_CSN: begin
				tx_tvalid = 1'b1;
				if (tx_tready) begin
					tx_load   = 1'b1;
					tx_sel    = illegal_reg_num ? cmd_pkg::TX_SEL_INV_CMD : cmd_pkg::TX_SEL_CMD;
					state_nxt = S_SEND_CMD;
				end
			end
			S_SEND_CMD: begin
				tx_tvalid = 1'b1;
				tx_tlast  = last_cmd;
				if (tx_tready) begin
					if (last_cmd) state_nxt = S_IDLE;
					else begin
						tx_load   = 1'b1;
						tx_sel    = cmd_pkg::TX_SEL_REG;
						state_nxt = S_SEND_REG;
					end
				end
			end
			S_SEND_REG: begin
				tx_tvalid = 1'b1;
				tx_tlast  = 1'b1;
				if (tx_tready) state_nxt = S_IDLE;
			end
			default: state_nxt = S_IDLE;
		endcase
	end

endmodule

/* verilog.f */
+incdir+dv
rtl/cmd_pkg.sv
rtl/config_regs.sv
rtl/loopback_engine.sv
rtl/reg_access_engine.sv
rtl/command_dispatch.sv
rtl/command_top.sv
dv/tb_command_top.sv
